/* logic/legIsaPkg.sv */
`default_nettype none

package legIsaPkg;

	localparam int instWidth = 32;
	localparam int dataWidth = 64;
	localparam int regIdxWidth = 5;
	localparam logic [regIdxWidth-1:0] xzrIdx = 5'd31; // Hardwired zero register

	// Instruction field widths
	localparam int dtAddrWidth = 9; // LDUR/STUR offset
	localparam int immWidth = 12; // ADDI immediate
	localparam int condBrWidth = 19;
	localparam int brWidth = 26;

	typedef enum logic [3:0] {
		opLdur,
		opStur,
		opAdd,
		opAddi,
		opSub,
		opAnd,
		opOrr,
		opCbz,
		opCbnz,
		opB,
		opHalt,
		opIllegal
	} opcodeE;

	localparam logic [10:0] ldurOpc = 11'b11111000010;
	localparam logic [10:0] sturOpc = 11'b11111000000;
	localparam logic [10:0] addOpc = 11'b10001011000;
	localparam logic [9:0] addiOpc = 10'b1001000100; // Only 10 bits wide
	localparam logic [10:0] subOpc = 11'b11001011000;
	localparam logic [10:0] andOpc = 11'b10001010000;
	localparam logic [10:0] orrOpc = 11'b10101010000;
	localparam logic [7:0] cbzOpc = 8'b10110100;
	localparam logic [7:0] cbnzOpc = 8'b10110101;
	localparam logic [5:0] bOpc = 6'b000101;
	localparam logic [10:0] haltOpc = 11'b11111111111;

endpackage

`default_nettype wire

/* logic/legCtrlPkg.sv */
`default_nettype none

package legCtrlPkg;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOrr,
		aluPassB
	} aluOpE;

	// Source of the second ALU operand
	typedef enum logic {
		srcReg,
		srcImm
	} aluSrcE;

	typedef enum logic [2:0] {
		stIdle,
		stFetch,
		stDecode,
		stExecute,
		stMemory,
		stWriteback,
		stHalted
	} ctrlStateE;

endpackage

`default_nettype wire

/* logic/legControl.sv */
`timescale 1ns/10ps
`default_nettype none

module legControl #(
	parameter int imemDepth = 64
) (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic [legIsaPkg::instWidth-1:0] instr,
	input  logic [legIsaPkg::dataWidth-1:0] aluResult,
	input  logic aluZero,
	input  logic storeReady,
	output logic [$clog2(imemDepth)-1:0] pc,
	output logic [legIsaPkg::regIdxWidth-1:0] rdIdx1,
	output logic [legIsaPkg::regIdxWidth-1:0] rdIdx2,
	output logic [legIsaPkg::regIdxWidth-1:0] wrIdx,
	output logic regWe,
	output logic wrSel,
	output legCtrlPkg::aluOpE aluOp,
	output legCtrlPkg::aluSrcE aluSrc,
	output logic [legIsaPkg::dataWidth-1:0] operandB,
	output logic [legIsaPkg::dataWidth-1:0] dmemAddr,
	output logic dmemWe,
	output logic storeValid,
	output logic [legIsaPkg::dataWidth-1:0] storeAddr,
	output logic [legIsaPkg::dataWidth-1:0] storeData,
	output logic busy,
	output logic halted,
	output logic illegal
);
	localparam int pcWidth = $clog2(imemDepth);

	legCtrlPkg::ctrlStateE state;
	legIsaPkg::opcodeE decOp;
	legIsaPkg::opcodeE opReg;
	logic [legIsaPkg::instWidth-1:0] instReg;
	logic [legIsaPkg::dataWidth-1:0] addrReg;
	logic [legIsaPkg::dataWidth-1:0] brOffset;
	logic [pcWidth-1:0] pcNext;
	logic reg2Loc;
	logic isBranch;
	logic brTaken;
	logic storeFire;

	assign decOp = (instr[31:21] == legIsaPkg::haltOpc) ? legIsaPkg::opHalt :
		(instr[31:21] == legIsaPkg::ldurOpc) ? legIsaPkg::opLdur :
		(instr[31:21] == legIsaPkg::sturOpc) ? legIsaPkg::opStur :
		(instr[31:21] == legIsaPkg::addOpc) ? legIsaPkg::opAdd :
		(instr[31:22] == legIsaPkg::addiOpc) ? legIsaPkg::opAddi :
		(instr[31:21] == legIsaPkg::subOpc) ? legIsaPkg::opSub :
		(instr[31:21] == legIsaPkg::andOpc) ? legIsaPkg::opAnd :
		(instr[31:21] == legIsaPkg::orrOpc) ? legIsaPkg::opOrr :
		(instr[31:24] == legIsaPkg::cbzOpc) ? legIsaPkg::opCbz :
		(instr[31:24] == legIsaPkg::cbnzOpc) ? legIsaPkg::opCbnz :
		(instr[31:26] == legIsaPkg::bOpc) ? legIsaPkg::opB :
		legIsaPkg::opIllegal;

	assign reg2Loc = (opReg == legIsaPkg::opStur) || (opReg == legIsaPkg::opCbz) ||
		(opReg == legIsaPkg::opCbnz); // Rt on second read port
	assign rdIdx1 = instReg[9:5];
	assign rdIdx2 = reg2Loc ? instReg[4:0] : instReg[20:16];
	assign wrIdx = instReg[4:0];

	assign isBranch = (opReg == legIsaPkg::opB) || (opReg == legIsaPkg::opCbz) ||
		(opReg == legIsaPkg::opCbnz);
	assign brTaken = (opReg == legIsaPkg::opB) || ((opReg == legIsaPkg::opCbz) && aluZero) ||
		((opReg == legIsaPkg::opCbnz) && !aluZero);
	assign brOffset = (opReg == legIsaPkg::opB) ?
		{{(legIsaPkg::dataWidth - legIsaPkg::brWidth){instReg[legIsaPkg::brWidth-1]}},
			instReg[0 +: legIsaPkg::brWidth]} :
		{{(legIsaPkg::dataWidth - legIsaPkg::condBrWidth){instReg[23]}},
			instReg[5 +: legIsaPkg::condBrWidth]};
	assign pcNext = pc + brOffset[pcWidth-1:0]; // Word offset

	always_comb
	begin
		aluOp = legCtrlPkg::aluAdd;
		aluSrc = legCtrlPkg::srcReg;
		operandB = {{(legIsaPkg::dataWidth - legIsaPkg::dtAddrWidth){1'b0}},
			instReg[12 +: legIsaPkg::dtAddrWidth]};
		case (opReg)
			legIsaPkg::opLdur, legIsaPkg::opStur:
				aluSrc = legCtrlPkg::srcImm;
			legIsaPkg::opAddi:
			begin
				aluSrc = legCtrlPkg::srcImm;
				operandB = {{(legIsaPkg::dataWidth - legIsaPkg::immWidth){1'b0}},
					instReg[10 +: legIsaPkg::immWidth]};
			end
			legIsaPkg::opSub:
				aluOp = legCtrlPkg::aluSub;
			legIsaPkg::opAnd:
				aluOp = legCtrlPkg::aluAnd;
			legIsaPkg::opOrr:
				aluOp = legCtrlPkg::aluOrr;
			legIsaPkg::opCbz, legIsaPkg::opCbnz, legIsaPkg::opB:
				aluOp = legCtrlPkg::aluPassB;
			default:
				aluOp = legCtrlPkg::aluAdd;
		endcase
		if (state == legCtrlPkg::stMemory) // Store data comes through the ALU
		begin
			aluOp = legCtrlPkg::aluPassB;
			aluSrc = legCtrlPkg::srcReg;
		end
	end

	assign storeValid = (state == legCtrlPkg::stMemory) && (opReg == legIsaPkg::opStur);
	assign storeFire = storeValid && storeReady;
	assign storeAddr = addrReg;
	assign storeData = aluResult;
	assign dmemAddr = addrReg;
	assign dmemWe = storeFire;
	assign regWe = (state == legCtrlPkg::stWriteback);
	assign wrSel = (opReg == legIsaPkg::opLdur); // Load data on writeback
	assign halted = (state == legCtrlPkg::stHalted);
	assign busy = !((state == legCtrlPkg::stIdle) || halted);

	always_ff @(posedge clk)
	begin
		if (state == legCtrlPkg::stDecode)
		begin
			instReg <= instr;
			opReg <= decOp;
		end
		if (state == legCtrlPkg::stExecute)
			addrReg <= aluResult;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= legCtrlPkg::stIdle;
			pc <= '0;
			illegal <= 1'b0;
		end
		else
		begin
			case (state)
				legCtrlPkg::stIdle, legCtrlPkg::stHalted:
					if (start)
					begin
						pc <= '0;
						illegal <= 1'b0;
						state <= legCtrlPkg::stFetch;
					end
				legCtrlPkg::stFetch:
					state <= legCtrlPkg::stDecode;
				legCtrlPkg::stDecode:
					if ((decOp == legIsaPkg::opHalt) || (decOp == legIsaPkg::opIllegal))
					begin
						illegal <= (decOp == legIsaPkg::opIllegal);
						state <= legCtrlPkg::stHalted;
					end
					else
						state <= legCtrlPkg::stExecute;
				legCtrlPkg::stExecute:
					if (isBranch)
					begin
						pc <= brTaken ? pcNext : pc + pcWidth'(1);
						state <= legCtrlPkg::stFetch;
					end
					else if ((opReg == legIsaPkg::opLdur) || (opReg == legIsaPkg::opStur))
						state <= legCtrlPkg::stMemory;
					else
						state <= legCtrlPkg::stWriteback;
				legCtrlPkg::stMemory:
					if (opReg == legIsaPkg::opLdur)
						state <= legCtrlPkg::stWriteback;
					else if (storeFire) // Back-pressure stretches this state
					begin
						pc <= pc + pcWidth'(1);
						state <= legCtrlPkg::stFetch;
					end
				legCtrlPkg::stWriteback:
				begin
					pc <= pc + pcWidth'(1);
					state <= legCtrlPkg::stFetch;
				end
				default:
					state <= legCtrlPkg::stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/legRegFile.sv */
`timescale 1ns/10ps
`default_nettype none

module legRegFile (
	input  logic clk,
	input  logic rstN,
	input  logic [legIsaPkg::regIdxWidth-1:0] rdIdx1,
	input  logic [legIsaPkg::regIdxWidth-1:0] rdIdx2,
	input  logic [legIsaPkg::regIdxWidth-1:0] wrIdx,
	input  logic [legIsaPkg::dataWidth-1:0] wrData,
	input  logic we,
	output logic [legIsaPkg::dataWidth-1:0] rdData1,
	output logic [legIsaPkg::dataWidth-1:0] rdData2
);
	logic [legIsaPkg::dataWidth-1:0] regs [0:legIsaPkg::xzrIdx-1]; // X0..X30

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < legIsaPkg::xzrIdx; i++)
				regs[i] <= '0;
		end
		else if (we && (wrIdx != legIsaPkg::xzrIdx))
			regs[wrIdx] <= wrData;
	end

	assign rdData1 = (rdIdx1 == legIsaPkg::xzrIdx) ? '0 : regs[rdIdx1];
	assign rdData2 = (rdIdx2 == legIsaPkg::xzrIdx) ? '0 : regs[rdIdx2];

endmodule

`default_nettype wire

/* logic/legAlu.sv */
`timescale 1ns/10ps
`default_nettype none

module legAlu (
	input  logic [legIsaPkg::dataWidth-1:0] a,
	input  logic [legIsaPkg::dataWidth-1:0] b,
	input  legCtrlPkg::aluOpE aluOp,
	output logic [legIsaPkg::dataWidth-1:0] result,
	output logic zero
);

	always_comb
	begin
		case (aluOp)
			legCtrlPkg::aluAdd:
				result = a + b;
			legCtrlPkg::aluSub:
				result = a - b;
			legCtrlPkg::aluAnd:
				result = a & b;
			legCtrlPkg::aluOrr:
				result = a | b;
			legCtrlPkg::aluPassB:
				result = b; // CBZ/CBNZ test and store data
			default:
				result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/legImem.sv */
`timescale 1ns/10ps
`default_nettype none

module legImem #(
	parameter int imemDepth = 64
) (
	input  logic clk,
	input  logic rstN,
	input  logic busy,
	input  logic progValid,
	input  logic [$clog2(imemDepth)-1:0] progAddr,
	input  logic [legIsaPkg::instWidth-1:0] progData,
	output logic progReady,
	input  logic [$clog2(imemDepth)-1:0] pc,
	output logic [legIsaPkg::instWidth-1:0] instr
);
	logic [legIsaPkg::instWidth-1:0] mem [imemDepth];

	assign progReady = !busy; // Loads only while idle or halted

	always_ff @(posedge clk)
	begin
		if (progValid && progReady)
			mem[progAddr] <= progData;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			instr <= '0;
		else
			instr <= mem[pc];
	end

endmodule

`default_nettype wire

/* logic/legDmem.sv */
`timescale 1ns/10ps
`default_nettype none

module legDmem #(
	parameter int dmemDepth = 32
) (
	input  logic clk,
	input  logic rstN,
	input  logic [legIsaPkg::dataWidth-1:0] addr,
	input  logic [legIsaPkg::dataWidth-1:0] wrData,
	input  logic we,
	output logic [legIsaPkg::dataWidth-1:0] rdData
);
	localparam int idxWidth = $clog2(dmemDepth);

	logic [legIsaPkg::dataWidth-1:0] mem [dmemDepth];
	logic [idxWidth-1:0] idx;

	assign idx = addr[3 +: idxWidth]; // Byte address to word index

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < dmemDepth; i++)
				mem[i] <= '0;
			rdData <= '0;
		end
		else
		begin
			if (we)
				mem[idx] <= wrData;
			rdData <= mem[idx]; // One cycle read latency
		end
	end

endmodule

`default_nettype wire

/* logic/legCore.sv */
`timescale 1ns/10ps
`default_nettype none

module legCore #(
	parameter int imemDepth = 64,
	parameter int dmemDepth = 32
) (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic progValid,
	input  logic [$clog2(imemDepth)-1:0] progAddr,
	input  logic [legIsaPkg::instWidth-1:0] progData,
	input  logic storeReady,
	output logic progReady,
	output logic storeValid,
	output logic [legIsaPkg::dataWidth-1:0] storeAddr,
	output logic [legIsaPkg::dataWidth-1:0] storeData,
	output logic halted,
	output logic illegal
);
	logic [$clog2(imemDepth)-1:0] pc;
	logic [legIsaPkg::instWidth-1:0] instr;
	logic [legIsaPkg::regIdxWidth-1:0] rdIdx1;
	logic [legIsaPkg::regIdxWidth-1:0] rdIdx2;
	logic [legIsaPkg::regIdxWidth-1:0] wrIdx;
	logic [legIsaPkg::dataWidth-1:0] rdData1;
	logic [legIsaPkg::dataWidth-1:0] rdData2;
	logic [legIsaPkg::dataWidth-1:0] wrData;
	logic [legIsaPkg::dataWidth-1:0] operandB;
	logic [legIsaPkg::dataWidth-1:0] aluB;
	logic [legIsaPkg::dataWidth-1:0] aluResult;
	logic [legIsaPkg::dataWidth-1:0] dmemAddr;
	logic [legIsaPkg::dataWidth-1:0] dmemRdData;
	legCtrlPkg::aluOpE aluOp;
	legCtrlPkg::aluSrcE aluSrc;
	logic aluZero;
	logic regWe;
	logic wrSel;
	logic dmemWe;
	logic busy;

	assign aluB = (aluSrc == legCtrlPkg::srcImm) ? operandB : rdData2;
	assign wrData = wrSel ? dmemRdData : aluResult; // Writeback select

	legControl #(
		.imemDepth(imemDepth)
	) u_legControl (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.instr(instr),
		.aluResult(aluResult),
		.aluZero(aluZero),
		.storeReady(storeReady),
		.pc(pc),
		.rdIdx1(rdIdx1),
		.rdIdx2(rdIdx2),
		.wrIdx(wrIdx),
		.regWe(regWe),
		.wrSel(wrSel),
		.aluOp(aluOp),
		.aluSrc(aluSrc),
		.operandB(operandB),
		.dmemAddr(dmemAddr),
		.dmemWe(dmemWe),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.busy(busy),
		.halted(halted),
		.illegal(illegal)
	);

	legRegFile u_legRegFile (
		.clk(clk),
		.rstN(rstN),
		.rdIdx1(rdIdx1),
		.rdIdx2(rdIdx2),
		.wrIdx(wrIdx),
		.wrData(wrData),
		.we(regWe),
		.rdData1(rdData1),
		.rdData2(rdData2)
	);

	legAlu u_legAlu (
		.a(rdData1),
		.b(aluB),
		.aluOp(aluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	legImem #(
		.imemDepth(imemDepth)
	) u_legImem (
		.clk(clk),
		.rstN(rstN),
		.busy(busy),
		.progValid(progValid),
		.progAddr(progAddr),
		.progData(progData),
		.progReady(progReady),
		.pc(pc),
		.instr(instr)
	);

	legDmem #(
		.dmemDepth(dmemDepth)
	) u_legDmem (
		.clk(clk),
		.rstN(rstN),
		.addr(dmemAddr),
		.wrData(storeData),
		.we(dmemWe),
		.rdData(dmemRdData)
	);

endmodule

`default_nettype wire

/* tb/legCoreChecks_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module legCoreChecks (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic progReady,
	input  logic storeValid,
	input  logic storeReady,
	input  logic [legIsaPkg::dataWidth-1:0] storeAddr,
	input  logic [legIsaPkg::dataWidth-1:0] storeData,
	input  logic halted
);
	int failCount = 0;

	storeHold: assert property (@(posedge clk) disable iff (!rstN)
		storeValid && !storeReady |=> storeValid && $stable(storeAddr) && $stable(storeData))
		else
		begin
			failCount++;
			$error("store dropped or changed before storeReady");
		end

	noStoreHalted: assert property (@(posedge clk) disable iff (!rstN)
		halted && !start |=> !storeValid)
		else
		begin
			failCount++;
			$error("storeValid high while halted");
		end

	// Loads blocked from start until halt
	loadBlocked: assert property (@(posedge clk) disable iff (!rstN)
		!progReady |=> !progReady || halted)
		else
		begin
			failCount++;
			$error("progReady high while the core runs");
		end

	startRuns: assert property (@(posedge clk) disable iff (!rstN)
		start && progReady |=> !progReady)
		else
		begin
			failCount++;
			$error("accepted start did not leave progReady low");
		end

endmodule

`default_nettype wire

/* tb/legCoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module legCoreTb;
	localparam int clkPeriod = 20;
	localparam int resetCycles = 16;
	localparam int rowBudget = 300; // Cycles per row with back-pressure
	localparam int imemDepth = 64;
	localparam int dmemDepth = 32;
	localparam logic [4:0] xzr = 5'd31;

	logic clk;
	logic rstN;
	logic start;
	logic progValid;
	logic [$clog2(imemDepth)-1:0] progAddr;
	logic [legIsaPkg::instWidth-1:0] progData;
	logic storeReady;
	logic progReady;
	logic storeValid;
	logic [legIsaPkg::dataWidth-1:0] storeAddr;
	logic [legIsaPkg::dataWidth-1:0] storeData;
	logic halted;
	logic illegal;

	// Test table, one entry per row
	legIsaPkg::opcodeE rowOp [$];
	logic [11:0] rowA [$];
	logic [11:0] rowB [$];
	logic [8:0] rowOff [$];
	logic rowBp [$];
	int rowStores [$];
	logic rowIllegal [$];

	logic [31:0] prog [$];
	logic [63:0] expAddr [$];
	logic [63:0] expData [$];
	logic [31:0] lfsr;
	int errorCount;
	int checkCount;
	int failedRows;

	legCore #(
		.imemDepth(imemDepth),
		.dmemDepth(dmemDepth)
	) u_legCore (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.progValid(progValid),
		.progAddr(progAddr),
		.progData(progData),
		.storeReady(storeReady),
		.progReady(progReady),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.halted(halted),
		.illegal(illegal)
	);

	bind legCore legCoreChecks u_legCoreChecks (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.progReady(progReady),
		.storeValid(storeValid),
		.storeReady(storeReady),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.halted(halted)
	);

	always #(clkPeriod / 2) clk = ~clk;

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic drawBit();
		drawBit = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // Galois step
	endfunction

	task automatic addRow(input legIsaPkg::opcodeE op, input logic [11:0] a,
		input logic [11:0] b, input logic [8:0] off, input logic bp, input int stores,
		input logic ill);
		rowOp.push_back(op);
		rowA.push_back(a);
		rowB.push_back(b);
		rowOff.push_back(off);
		rowBp.push_back(bp);
		rowStores.push_back(stores);
		rowIllegal.push_back(ill);
	endtask

	// op, a, b, offset, back-pressure, stores, illegal
	task automatic fillTable();
		addRow(legIsaPkg::opAdd, 12'h123, 12'h456, 9'd0, 1'b0, 1, 1'b0);
		addRow(legIsaPkg::opAddi, 12'hfff, 12'h001, 9'd16, 1'b0, 1, 1'b0);
		addRow(legIsaPkg::opSub, 12'h010, 12'h020, 9'd32, 1'b0, 1, 1'b0); // Wraps negative
		addRow(legIsaPkg::opAnd, 12'hf0f, 12'h3c3, 9'd48, 1'b1, 1, 1'b0);
		addRow(legIsaPkg::opOrr, 12'h505, 12'h0a0, 9'd64, 1'b1, 1, 1'b0);
		addRow(legIsaPkg::opLdur, 12'h7a5, 12'h000, 9'd80, 1'b1, 2, 1'b0);
		addRow(legIsaPkg::opCbz, 12'h111, 12'h000, 9'd96, 1'b0, 1, 1'b0);
		addRow(legIsaPkg::opCbz, 12'h222, 12'h005, 9'd112, 1'b1, 2, 1'b0);
		addRow(legIsaPkg::opCbnz, 12'h333, 12'h000, 9'd128, 1'b0, 2, 1'b0);
		addRow(legIsaPkg::opCbnz, 12'h444, 12'h007, 9'd144, 1'b1, 1, 1'b0);
		addRow(legIsaPkg::opB, 12'h555, 12'h009, 9'd160, 1'b0, 1, 1'b0);
		addRow(legIsaPkg::opHalt, 12'h666, 12'h00a, 9'd176, 1'b0, 0, 1'b0);
		addRow(legIsaPkg::opIllegal, 12'h777, 12'h00b, 9'd192, 1'b0, 0, 1'b1);
		addRow(legIsaPkg::opSub, 12'hfff, 12'h001, 9'd208, 1'b1, 1, 1'b0);
	endtask

	function automatic logic [31:0] encR(input logic [10:0] opc, input logic [4:0] rm,
		input logic [4:0] rn, input logic [4:0] rd);
		encR = {opc, rm, 6'd0, rn, rd};
	endfunction

	function automatic logic [31:0] encAddi(input logic [11:0] imm, input logic [4:0] rn,
		input logic [4:0] rd);
		encAddi = {legIsaPkg::addiOpc, imm, rn, rd};
	endfunction

	function automatic logic [31:0] encD(input logic [10:0] opc, input logic [8:0] off,
		input logic [4:0] rn, input logic [4:0] rt);
		encD = {opc, off, 2'b00, rn, rt};
	endfunction

	function automatic logic [31:0] encCb(input logic [7:0] opc, input logic [18:0] off,
		input logic [4:0] rt);
		encCb = {opc, off, rt};
	endfunction

	function automatic logic [10:0] rOpc(input legIsaPkg::opcodeE op);
		case (op)
			legIsaPkg::opSub:
				rOpc = legIsaPkg::subOpc;
			legIsaPkg::opAnd:
				rOpc = legIsaPkg::andOpc;
			legIsaPkg::opOrr:
				rOpc = legIsaPkg::orrOpc;
			default:
				rOpc = legIsaPkg::addOpc;
		endcase
	endfunction

	function automatic logic [63:0] aluModel(input legIsaPkg::opcodeE op,
		input logic [63:0] a, input logic [63:0] b);
		case (op)
			legIsaPkg::opSub:
				aluModel = a - b;
			legIsaPkg::opAnd:
				aluModel = a & b;
			legIsaPkg::opOrr:
				aluModel = a | b;
			default:
				aluModel = a + b; // ADD and ADDI
		endcase
	endfunction

	// Program and expected stores for one row
	task automatic buildProgram(input int i);
		legIsaPkg::opcodeE op;
		logic [63:0] a;
		logic [63:0] b;
		logic [8:0] off;
		logic taken;
		op = rowOp[i];
		a = {52'd0, rowA[i]};
		b = {52'd0, rowB[i]};
		off = rowOff[i];
		prog.delete();
		expAddr.delete();
		expData.delete();
		prog.push_back(encAddi(rowA[i], xzr, 5'd1));
		prog.push_back(encAddi(rowB[i], xzr, 5'd2));
		case (op)
			legIsaPkg::opAdd, legIsaPkg::opSub, legIsaPkg::opAnd, legIsaPkg::opOrr,
			legIsaPkg::opAddi:
			begin
				if (op == legIsaPkg::opAddi)
					prog.push_back(encAddi(rowB[i], 5'd1, 5'd3));
				else
					prog.push_back(encR(rOpc(op), 5'd2, 5'd1, 5'd3));
				prog.push_back(encD(legIsaPkg::sturOpc, off, xzr, 5'd3));
				expAddr.push_back({55'd0, off});
				expData.push_back(aluModel(op, a, b));
			end
			legIsaPkg::opLdur:
			begin
				prog.push_back(encD(legIsaPkg::sturOpc, off, xzr, 5'd1));
				prog.push_back(encD(legIsaPkg::ldurOpc, off, xzr, 5'd4));
				prog.push_back(encD(legIsaPkg::sturOpc, off + 9'd8, xzr, 5'd4));
				expAddr.push_back({55'd0, off});
				expData.push_back(a);
				expAddr.push_back({55'd0, off + 9'd8});
				expData.push_back(a);
			end
			legIsaPkg::opCbz, legIsaPkg::opCbnz, legIsaPkg::opB:
			begin
				if (op == legIsaPkg::opCbz)
					prog.push_back(encCb(legIsaPkg::cbzOpc, 19'd2, 5'd2));
				else if (op == legIsaPkg::opCbnz)
					prog.push_back(encCb(legIsaPkg::cbnzOpc, 19'd2, 5'd2));
				else
					prog.push_back({legIsaPkg::bOpc, 26'd2});
				prog.push_back(encD(legIsaPkg::sturOpc, off, xzr, 5'd1)); // Marker store
				prog.push_back(encD(legIsaPkg::sturOpc, off + 9'd8, xzr, 5'd2));
				taken = (op == legIsaPkg::opB) || ((op == legIsaPkg::opCbz) && (b == 0)) ||
					((op == legIsaPkg::opCbnz) && (b != 0));
				if (!taken)
				begin
					expAddr.push_back({55'd0, off});
					expData.push_back(a);
				end
				expAddr.push_back({55'd0, off + 9'd8});
				expData.push_back(b);
			end
			legIsaPkg::opHalt:
			begin
				prog.push_back({legIsaPkg::haltOpc, 21'd0});
				prog.push_back(encD(legIsaPkg::sturOpc, off, xzr, 5'd1)); // Never reached
			end
			default:
			begin
				prog.push_back(32'h0000_0000); // Matches no opcode
				prog.push_back(encD(legIsaPkg::sturOpc, off, xzr, 5'd1));
			end
		endcase
		prog.push_back({legIsaPkg::haltOpc, 21'd0});
	endtask

	task automatic checkReset();
		int firstErr;
		firstErr = errorCount;
		checkValue("progReady", 64'(progReady), 64'd1);
		checkValue("halted", 64'(halted), 64'd0);
		checkValue("storeValid", 64'(storeValid), 64'd0);
		checkValue("illegal", 64'(illegal), 64'd0);
		$display("reset: %s", (errorCount == firstErr) ? "ok" : "FAIL");
	endtask

	task automatic runRow(input int i);
		legIsaPkg::opcodeE op;
		int firstErr;
		logic rdy;
		logic pending;
		logic [63:0] heldAddr;
		logic [63:0] heldData;
		logic [63:0] gotAddr [$];
		logic [63:0] gotData [$];
		op = rowOp[i];
		firstErr = errorCount;
		buildProgram(i);
		for (int w = 0; w < prog.size(); w++)
		begin
			progValid = 1'b1;
			progAddr = w[$clog2(imemDepth)-1:0];
			progData = prog[w];
			checkValue("progReady", 64'(progReady), 64'd1); // Idle or halted core takes loads
			while (!progReady)
			begin
				@(posedge clk);
				#2;
			end
			@(posedge clk); // Accepted at this edge
			#2;
		end
		progValid = 1'b0;

		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		checkValue("progReady", 64'(progReady), 64'd0);
		checkValue("halted", 64'(halted), 64'd0);
		checkValue("illegal", 64'(illegal), 64'd0); // Cleared by start

		pending = 1'b0;
		while (!halted)
		begin
			if (rowBp[i])
				rdy = drawBit();
			else
				rdy = 1'b1;
			storeReady = rdy;
			if (pending)
			begin
				checkValue("storeValid", 64'(storeValid), 64'd1);
				checkValue("storeAddr", storeAddr, heldAddr);
				checkValue("storeData", storeData, heldData);
			end
			if (storeValid && rdy)
			begin
				gotAddr.push_back(storeAddr);
				gotData.push_back(storeData);
				pending = 1'b0;
			end
			else if (storeValid)
			begin
				heldAddr = storeAddr;
				heldData = storeData;
				pending = 1'b1;
			end
			@(posedge clk);
			#2;
		end
		storeReady = 1'b1;

		checkValue("storeCount", 64'(gotAddr.size()), 64'(rowStores[i]));
		for (int k = 0; (k < expAddr.size()) && (k < gotAddr.size()); k++)
		begin
			checkValue($sformatf("storeAddr[%0d]", k), gotAddr[k], expAddr[k]);
			checkValue($sformatf("storeData[%0d]", k), gotData[k], expData[k]);
		end
		checkValue("illegal", 64'(illegal), 64'(rowIllegal[i]));
		repeat (2)
		begin
			@(posedge clk);
			#2;
			checkValue("halted", 64'(halted), 64'd1);
			checkValue("storeValid", 64'(storeValid), 64'd0); // Nothing after halt
		end
		if (errorCount != firstErr)
			failedRows++;
		$display("row %0d %s: %s", i, op.name(), (errorCount == firstErr) ? "ok" : "FAIL");
	endtask

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		start = 1'b0;
		progValid = 1'b0;
		progAddr = '0;
		progData = '0;
		storeReady = 1'b1;
		errorCount = 0;
		checkCount = 0;
		failedRows = 0;
		lfsr = 32'h50cc_cd3b;
		fillTable();
		repeat (resetCycles) @(posedge clk);
		#2;
		rstN = 1'b1;
		@(posedge clk);
		#2;
		checkReset();
		for (int i = 0; i < rowOp.size(); i++)
			runRow(i);
		$display("%0d rows, %0d failed, %0d checks, %0d mismatches, %0d assertion failures",
			rowOp.size(), failedRows, checkCount, errorCount,
			u_legCore.u_legCoreChecks.failCount);
		if ((errorCount == 0) && (u_legCore.u_legCoreChecks.failCount == 0))
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog sized from the table length
	initial
	begin
		int limit;
		#1;
		limit = (resetCycles + rowOp.size() * rowBudget) * clkPeriod;
		#(limit);
		$display("timeout: the tests did not finish within %0d ns", limit);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
logic/legIsaPkg.sv
logic/legCtrlPkg.sv
logic/legControl.sv
logic/legRegFile.sv
logic/legAlu.sv
logic/legImem.sv
logic/legDmem.sv
logic/legCore.sv
tb/legCoreChecks_sva.sv
tb/legCoreTb.sv

/* Makefile */
TOP := legCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
